/* src/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN   = 64;
    localparam int REG_AW = 5;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
    } br_op_e;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]       imm;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } i_fmt_t;

    typedef struct packed {
        logic              imm12;
        logic [5:0]        imm10_5;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [3:0]        imm4_1;
        logic              imm11;
        logic [6:0]        opcode;
    } b_fmt_t;

    // jump field order, bits 31:12 in sequence also form the u immediate
    typedef struct packed {
        logic              imm20;
        logic [9:0]        imm10_1;
        logic              imm11;
        logic [7:0]        imm19_12;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } uj_fmt_t;

    typedef union packed {
        r_fmt_t  r;
        i_fmt_t  i;
        b_fmt_t  b;
        uj_fmt_t uj;
    } rv_instr_u;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
        logic [XLEN-1:0]   imm;
        alu_op_e           alu_op;
        br_op_e            br_op;
        logic [REG_AW-1:0] rd;
        logic              wen;
        logic              link;     // result is pc+4
        logic              jalr;     // target is a+imm
        logic              illegal;
        logic              valid;
    } uop_t;

endpackage

/* src/uop_if.sv */
interface uop_if;

    logic         valid;
    rv_pkg::uop_t payload;

    modport src (
        output valid,
        output payload
    );

    modport dst (
        input valid,
        input payload
    );

endinterface

/* src/rv_regfile.sv */
module rv_regfile (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [rv_pkg::REG_AW-1:0] raddr1_i,
    input  logic [rv_pkg::REG_AW-1:0] raddr2_i,
    output logic [rv_pkg::XLEN-1:0]   rdata1_o,
    output logic [rv_pkg::XLEN-1:0]   rdata2_o,
    input  logic                      wen_i,
    input  logic [rv_pkg::REG_AW-1:0] waddr_i,
    input  logic [rv_pkg::XLEN-1:0]   wdata_i
);

    logic [rv_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];  // x0 reads zero
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

/* src/rv_decode.sv */
module rv_decode (
    input  logic                      instr_valid_i,
    input  logic [31:0]               instr_i,
    input  logic [rv_pkg::XLEN-1:0]   pc_i,
    output logic [rv_pkg::REG_AW-1:0] rf_raddr1_o,
    output logic [rv_pkg::REG_AW-1:0] rf_raddr2_o,
    input  logic [rv_pkg::XLEN-1:0]   rf_rdata1_i,
    input  logic [rv_pkg::XLEN-1:0]   rf_rdata2_i,
    input  logic                      fwd1_valid_i,
    input  logic [rv_pkg::REG_AW-1:0] fwd1_rd_i,
    input  logic [rv_pkg::XLEN-1:0]   fwd1_data_i,
    input  logic                      fwd2_valid_i,
    input  logic [rv_pkg::REG_AW-1:0] fwd2_rd_i,
    input  logic [rv_pkg::XLEN-1:0]   fwd2_data_i,
    uop_if.src                        uop
);

    rv_pkg::rv_instr_u       ins;
    rv_pkg::uop_t            u;
    logic [rv_pkg::XLEN-1:0] imm_i, imm_b, imm_u, imm_j;
    logic [rv_pkg::XLEN-1:0] rs1_val, rs2_val;
    logic [2:0]              f3;

    assign ins = instr_i;
    assign f3  = ins.r.funct3;

    assign imm_i = {{52{ins.i.imm[11]}}, ins.i.imm};
    assign imm_b = {{52{ins.b.imm12}}, ins.b.imm11, ins.b.imm10_5, ins.b.imm4_1, 1'b0};
    assign imm_u = {{32{ins.uj.imm20}}, ins.uj.imm20, ins.uj.imm10_1, ins.uj.imm11,
                    ins.uj.imm19_12, 12'b0};
    assign imm_j = {{44{ins.uj.imm20}}, ins.uj.imm19_12, ins.uj.imm11, ins.uj.imm10_1, 1'b0};

    assign rf_raddr1_o = ins.r.rs1;
    assign rf_raddr2_o = ins.r.rs2;

    // newest producer wins: execute, then writeback, then regfile
    always_comb begin
        if (fwd1_valid_i && fwd1_rd_i == ins.r.rs1)       rs1_val = fwd1_data_i;
        else if (fwd2_valid_i && fwd2_rd_i == ins.r.rs1)  rs1_val = fwd2_data_i;
        else                                              rs1_val = rf_rdata1_i;
    end

    always_comb begin
        if (fwd1_valid_i && fwd1_rd_i == ins.r.rs2)       rs2_val = fwd1_data_i;
        else if (fwd2_valid_i && fwd2_rd_i == ins.r.rs2)  rs2_val = fwd2_data_i;
        else                                              rs2_val = rf_rdata2_i;
    end

    always_comb begin
        u        = '0;
        u.pc     = pc_i;
        u.a      = rs1_val;
        u.b      = rs2_val;
        u.rd     = ins.r.rd;
        u.valid  = instr_valid_i;
        u.alu_op = rv_pkg::ALU_ADD;
        u.br_op  = rv_pkg::BR_NONE;
        case (ins.r.opcode)
            rv_pkg::OPC_OP: begin
                u.wen = 1'b1;
                case (f3)
                    3'd0: u.alu_op = ins.r.funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'd1: u.alu_op = rv_pkg::ALU_SLL;
                    3'd2: u.alu_op = rv_pkg::ALU_SLT;
                    3'd3: u.alu_op = rv_pkg::ALU_SLTU;
                    3'd4: u.alu_op = rv_pkg::ALU_XOR;
                    3'd5: u.alu_op = ins.r.funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'd6: u.alu_op = rv_pkg::ALU_OR;
                    default: u.alu_op = rv_pkg::ALU_AND;
                endcase
                // funct7 0x20 only for sub and sra
                u.illegal = !(ins.r.funct7 == 7'h00 ||
                              (ins.r.funct7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
            end
            rv_pkg::OPC_OP_IMM: begin
                u.wen = 1'b1;
                u.imm = imm_i;
                u.b   = imm_i;
                case (f3)
                    3'd0: u.alu_op = rv_pkg::ALU_ADD;
                    3'd1: begin
                        u.alu_op  = rv_pkg::ALU_SLL;
                        u.illegal = ins.i.imm[11:6] != 6'b0;
                    end
                    3'd2: u.alu_op = rv_pkg::ALU_SLT;
                    3'd3: u.alu_op = rv_pkg::ALU_SLTU;
                    3'd4: u.alu_op = rv_pkg::ALU_XOR;
                    3'd5: begin
                        u.alu_op  = ins.i.imm[10] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        u.illegal = ins.i.imm[11:6] != {1'b0, ins.i.imm[10], 4'b0};
                    end
                    3'd6: u.alu_op = rv_pkg::ALU_OR;
                    default: u.alu_op = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::OPC_LUI: begin
                u.wen    = 1'b1;
                u.imm    = imm_u;
                u.b      = imm_u;
                u.alu_op = rv_pkg::ALU_PASS_B;
            end
            rv_pkg::OPC_AUIPC: begin
                u.wen = 1'b1;
                u.imm = imm_u;
                u.a   = pc_i;   // pc+imm through the adder
                u.b   = imm_u;
            end
            rv_pkg::OPC_JAL: begin
                u.wen   = 1'b1;
                u.imm   = imm_j;
                u.link  = 1'b1;
                u.br_op = rv_pkg::BR_JUMP;
            end
            rv_pkg::OPC_JALR: begin
                u.wen     = 1'b1;
                u.imm     = imm_i;
                u.link    = 1'b1;
                u.jalr    = 1'b1;
                u.br_op   = rv_pkg::BR_JUMP;
                u.illegal = f3 != 3'd0;
            end
            rv_pkg::OPC_BRANCH: begin
                u.imm = imm_b;
                case (f3)
                    3'd0: u.br_op = rv_pkg::BR_EQ;
                    3'd1: u.br_op = rv_pkg::BR_NE;
                    3'd4: u.br_op = rv_pkg::BR_LT;
                    3'd5: u.br_op = rv_pkg::BR_GE;
                    3'd6: u.br_op = rv_pkg::BR_LTU;
                    3'd7: u.br_op = rv_pkg::BR_GEU;
                    default: u.illegal = 1'b1;
                endcase
            end
            default: u.illegal = 1'b1;
        endcase
        if (u.illegal) begin  // nothing visible but the flag
            u.wen   = 1'b0;
            u.link  = 1'b0;
            u.jalr  = 1'b0;
            u.br_op = rv_pkg::BR_NONE;
        end
        if (u.rd == '0) u.wen = 1'b0;
    end

    assign uop.valid   = instr_valid_i;
    assign uop.payload = u;

endmodule

/* src/id_ex_regs.sv */
module id_ex_regs (
    input logic clk,
    input logic rst_n,
    uop_if.dst  in,
    uop_if.src  out
);

    // a bubble stores an all-zero micro-op
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.valid   <= 1'b0;
            out.payload <= '0;
        end else begin
            out.valid   <= in.valid;
            out.payload <= in.valid ? in.payload : '0;
        end
    end

endmodule

/* src/rv_execute.sv */
module rv_execute (
    uop_if.dst                        uop,
    output logic                      res_valid_o,
    output logic [rv_pkg::REG_AW-1:0] res_rd_o,
    output logic                      res_wen_o,
    output logic [rv_pkg::XLEN-1:0]   res_data_o,
    output logic                      res_taken_o,
    output logic [rv_pkg::XLEN-1:0]   res_target_o,
    output logic                      res_illegal_o
);

    rv_pkg::uop_t            u;
    logic [rv_pkg::XLEN-1:0] a, b, alu_res, jalr_sum;
    logic [5:0]              shamt;
    logic                    cond, live;

    assign u     = uop.payload;
    assign a     = u.a;
    assign b     = u.b;   // register value or immediate, picked at decode
    assign shamt = b[5:0];
    assign live  = uop.valid & u.valid;

    always_comb begin
        case (u.alu_op)
            rv_pkg::ALU_ADD:    alu_res = a + b;
            rv_pkg::ALU_SUB:    alu_res = a - b;
            rv_pkg::ALU_AND:    alu_res = a & b;
            rv_pkg::ALU_OR:     alu_res = a | b;
            rv_pkg::ALU_XOR:    alu_res = a ^ b;
            rv_pkg::ALU_SLL:    alu_res = a << shamt;
            rv_pkg::ALU_SRL:    alu_res = a >> shamt;
            rv_pkg::ALU_SRA:    alu_res = $signed(a) >>> shamt;
            rv_pkg::ALU_SLT:    alu_res = {63'b0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU:   alu_res = {63'b0, a < b};
            rv_pkg::ALU_PASS_B: alu_res = b;
            default:            alu_res = '0;
        endcase
    end

    always_comb begin
        case (u.br_op)
            rv_pkg::BR_EQ:   cond = a == b;
            rv_pkg::BR_NE:   cond = a != b;
            rv_pkg::BR_LT:   cond = $signed(a) < $signed(b);
            rv_pkg::BR_GE:   cond = $signed(a) >= $signed(b);
            rv_pkg::BR_LTU:  cond = a < b;
            rv_pkg::BR_GEU:  cond = a >= b;
            rv_pkg::BR_JUMP: cond = 1'b1;
            default:         cond = 1'b0;
        endcase
    end

    assign jalr_sum = a + u.imm;

    assign res_valid_o   = live;
    assign res_rd_o      = u.rd;
    assign res_wen_o     = live & u.wen;
    assign res_data_o    = u.link ? u.pc + 64'd4 : alu_res;
    assign res_taken_o   = live & cond;
    assign res_illegal_o = live & u.illegal;

    // target only reported when taken
    always_comb begin
        if (!res_taken_o) res_target_o = '0;
        else if (u.jalr)  res_target_o = {jalr_sum[rv_pkg::XLEN-1:1], 1'b0};
        else              res_target_o = u.pc + u.imm;
    end

endmodule

/* src/rv_writeback.sv */
module rv_writeback (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      res_valid_i,
    input  logic [rv_pkg::REG_AW-1:0] res_rd_i,
    input  logic                      res_wen_i,
    input  logic [rv_pkg::XLEN-1:0]   res_data_i,
    input  logic                      res_taken_i,
    input  logic [rv_pkg::XLEN-1:0]   res_target_i,
    input  logic                      res_illegal_i,
    output logic                      fwd1_valid_o,
    output logic [rv_pkg::REG_AW-1:0] fwd1_rd_o,
    output logic [rv_pkg::XLEN-1:0]   fwd1_data_o,
    output logic                      rf_wen_o,
    output logic [rv_pkg::REG_AW-1:0] rf_waddr_o,
    output logic [rv_pkg::XLEN-1:0]   rf_wdata_o,
    output logic                      wb_valid_o,
    output logic [rv_pkg::REG_AW-1:0] wb_rd_o,
    output logic [rv_pkg::XLEN-1:0]   wb_data_o,
    output logic                      wb_wen_o,
    output logic                      branch_taken_o,
    output logic [rv_pkg::XLEN-1:0]   branch_target_o,
    output logic                      illegal_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_o     <= 1'b0;
            wb_wen_o       <= 1'b0;
            branch_taken_o <= 1'b0;
            illegal_o      <= 1'b0;
        end else begin
            wb_valid_o     <= res_valid_i;
            wb_wen_o       <= res_valid_i & res_wen_i & (res_rd_i != '0);
            branch_taken_o <= res_taken_i;
            illegal_o      <= res_illegal_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o         <= res_rd_i;
        wb_data_o       <= res_data_i;
        branch_target_o <= res_target_i;
    end

    // stage 1 bypass straight from execute
    assign fwd1_valid_o = res_valid_i & res_wen_i & (res_rd_i != '0);
    assign fwd1_rd_o    = res_rd_i;
    assign fwd1_data_o  = res_data_i;

    // regfile takes it on the next edge, stage 2 bypass in between
    assign rf_wen_o   = wb_wen_o;
    assign rf_waddr_o = wb_rd_o;
    assign rf_wdata_o = wb_data_o;

endmodule

/* src/rv_exec_slice.sv */
module rv_exec_slice (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid_i,
    input  logic [31:0]               instr_i,
    input  logic [rv_pkg::XLEN-1:0]   pc_i,
    output logic                      wb_valid_o,
    output logic                      wb_wen_o,
    output logic [rv_pkg::REG_AW-1:0] wb_rd_o,
    output logic [rv_pkg::XLEN-1:0]   wb_data_o,
    output logic                      branch_taken_o,
    output logic [rv_pkg::XLEN-1:0]   branch_target_o,
    output logic                      illegal_o
);

    logic [rv_pkg::REG_AW-1:0] raddr1, raddr2, rf_waddr, fwd1_rd, res_rd;
    logic [rv_pkg::XLEN-1:0]   rdata1, rdata2, rf_wdata, fwd1_data, res_data, res_target;
    logic                      rf_wen, fwd1_valid;
    logic                      res_valid, res_wen, res_taken, res_illegal;

    uop_if dec_uop ();
    uop_if ex_uop ();

    rv_regfile u_regfile (
        .clk, .rst_n,
        .raddr1_i(raddr1), .raddr2_i(raddr2), .rdata1_o(rdata1), .rdata2_o(rdata2),
        .wen_i(rf_wen), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
    );

    rv_decode u_decode (
        .instr_valid_i, .instr_i, .pc_i,
        .rf_raddr1_o(raddr1), .rf_raddr2_o(raddr2),
        .rf_rdata1_i(rdata1), .rf_rdata2_i(rdata2),
        .fwd1_valid_i(fwd1_valid), .fwd1_rd_i(fwd1_rd), .fwd1_data_i(fwd1_data),
        .fwd2_valid_i(rf_wen), .fwd2_rd_i(rf_waddr), .fwd2_data_i(rf_wdata),
        .uop(dec_uop.src)
    );

    id_ex_regs u_id_ex_regs (
        .clk, .rst_n,
        .in(dec_uop.dst),
        .out(ex_uop.src)
    );

    rv_execute u_execute (
        .uop(ex_uop.dst),
        .res_valid_o(res_valid), .res_rd_o(res_rd), .res_wen_o(res_wen),
        .res_data_o(res_data), .res_taken_o(res_taken), .res_target_o(res_target),
        .res_illegal_o(res_illegal)
    );

    rv_writeback u_writeback (
        .clk, .rst_n,
        .res_valid_i(res_valid), .res_rd_i(res_rd), .res_wen_i(res_wen),
        .res_data_i(res_data), .res_taken_i(res_taken), .res_target_i(res_target),
        .res_illegal_i(res_illegal),
        .fwd1_valid_o(fwd1_valid), .fwd1_rd_o(fwd1_rd), .fwd1_data_o(fwd1_data),
        .rf_wen_o(rf_wen), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .wb_valid_o, .wb_rd_o, .wb_data_o, .wb_wen_o,
        .branch_taken_o, .branch_target_o, .illegal_o
    );

endmodule

/* bench/rv_exec_slice_chk.sv */
module rv_exec_slice_chk (
    input logic       clk,
    input logic       rst_n,
    input logic       instr_valid_i,
    input logic       wb_valid_o,
    input logic       wb_wen_o,
    input logic [4:0] wb_rd_o,
    input logic       illegal_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;   // failed assertions so far

    // accepted at E0, output sampled at the edge after E0+1
    a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid_i |-> ##2 wb_valid_o)
        else begin
            fail_count++;
            $error("input valid without matching output");
        end

    a_no_extra_out: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid_o |-> $past(instr_valid_i, 2))
        else begin
            fail_count++;
            $error("output without matching input");
        end

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_wen_o |-> wb_rd_o != 5'd0)
        else begin
            fail_count++;
            $error("write reported to x0");
        end

    a_illegal_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        illegal_o |-> !wb_wen_o)
        else begin
            fail_count++;
            $error("write reported with illegal");
        end

endmodule

bind rv_exec_slice rv_exec_slice_chk u_chk (.*);

/* bench/tb_rv_exec_slice.sv */
module tb_rv_exec_slice;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_ALU    = 400;
    localparam int N_UPPER  = 40;
    localparam int N_BRANCH = 48;
    localparam int N_X0ILL  = 48;
    localparam int N_BUBBLE = 100;
    localparam int N_TOTAL  = N_ALU + N_UPPER + N_BRANCH + N_X0ILL + N_BUBBLE;
    localparam int CYCLE_LIMIT = N_TOTAL * 2 + 50;

    typedef struct {
        logic        wen;
        logic [4:0]  rd;
        logic [63:0] data;
        logic        taken;
        logic [63:0] target;
        logic        illegal;
    } exp_t;

    logic clk = 1'b0;
    logic rst_n;
    logic instr_valid_i;
    logic [31:0] instr_i;
    logic [63:0] pc_i;
    logic wb_valid_o, wb_wen_o, branch_taken_o, illegal_o;
    logic [4:0] wb_rd_o;
    logic [63:0] wb_data_o, branch_target_o;

    logic [63:0] mregs [32];   // model register file
    exp_t exp_q [$];
    string cur_test = "reset";
    int errors = 0;
    int tests_done = 0;
    int cycles = 0;

    rv_exec_slice u_rv_exec_slice (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles in test %s", CYCLE_LIMIT, cur_test);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check(input string field, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s: expected %h, actual %h", cur_test, field, exp, act);
        end
    endtask

    function automatic logic [63:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [63:0] a, input logic [63:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return {63'b0, $signed(a) < $signed(b)};
            3'd3: return {63'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA reference: expected outputs, model regfile updated in program order
    task automatic predict(input logic [31:0] w, input logic [63:0] pc);
        rv_pkg::rv_instr_u ins;
        exp_t e;
        logic [63:0] x1v, x2v, ii, ib, iu, ij, r;
        logic wr;
        logic [2:0] f3;
        ins = w;
        e = '{default: '0};
        wr = 1'b0;
        r = '0;
        f3 = ins.r.funct3;
        x1v = mregs[ins.r.rs1];
        x2v = mregs[ins.r.rs2];
        ii = {{52{w[31]}}, w[31:20]};
        ib = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        iu = {{32{w[31]}}, w[31:12], 12'b0};
        ij = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        case (ins.r.opcode)
            rv_pkg::OPC_OP: begin
                // only sub and sra take funct7 0x20
                e.illegal = ins.r.funct7 != 7'h00 &&
                            !(ins.r.funct7 == 7'h20 && f3 inside {3'd0, 3'd5});
                r = alu(f3, ins.r.funct7[5], x1v, x2v);
                wr = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                if (f3 == 3'd1) e.illegal = w[31:26] != 6'h00;
                if (f3 == 3'd5) e.illegal = !(w[31:26] == 6'h00 || w[31:26] == 6'h10);
                r = alu(f3, f3 == 3'd5 && w[30], x1v, ii);
                wr = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                r = iu;
                wr = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                r = pc + iu;
                wr = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                r = pc + 64'd4;
                wr = 1'b1;
                e.taken = 1'b1;
                e.target = pc + ij;
            end
            rv_pkg::OPC_JALR: begin
                e.illegal = f3 != 3'd0;
                r = pc + 64'd4;
                wr = 1'b1;
                e.taken = 1'b1;
                e.target = (x1v + ii) & ~64'd1;
            end
            rv_pkg::OPC_BRANCH: begin
                case (f3)
                    3'd0: e.taken = x1v == x2v;
                    3'd1: e.taken = x1v != x2v;
                    3'd4: e.taken = $signed(x1v) < $signed(x2v);
                    3'd5: e.taken = $signed(x1v) >= $signed(x2v);
                    3'd6: e.taken = x1v < x2v;
                    3'd7: e.taken = x1v >= x2v;
                    default: e.illegal = 1'b1;
                endcase
                if (e.taken) e.target = pc + ib;
            end
            default: e.illegal = 1'b1;
        endcase
        if (e.illegal) begin
            e.taken = 1'b0;
            e.target = '0;
        end
        e.rd = ins.r.rd;
        if (!e.illegal && wr && e.rd != 5'd0) begin
            e.wen = 1'b1;
            e.data = r;
            mregs[e.rd] = r;
        end
        exp_q.push_back(e);
    endtask

    // output monitor, sampled mid-cycle
    always @(negedge clk) begin
        exp_t e;
        if (rst_n && wb_valid_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("output appeared in test %s with no instruction outstanding", cur_test);
            end else begin
                e = exp_q.pop_front();
                check("wen", 64'(e.wen), 64'(wb_wen_o));
                if (e.wen) begin
                    check("rd", 64'(e.rd), 64'(wb_rd_o));
                    check("data", e.data, wb_data_o);
                end
                check("taken", 64'(e.taken), 64'(branch_taken_o));
                check("target", e.target, branch_target_o);
                check("illegal", 64'(e.illegal), 64'(illegal_o));
            end
        end
    end

    task automatic send(input logic [31:0] w, input logic [63:0] pc);
        instr_valid_i = 1'b1;
        instr_i = w;
        pc_i = pc;
        predict(w, pc);
        @(posedge clk);
        #1;
        instr_valid_i = 1'b0;
    endtask

    task automatic idle(input int n);
        instr_valid_i = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_test(input int err_before);
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        tests_done++;
        $display("%s: done, %0d errors", cur_test, errors - err_before);
    endtask

    function automatic logic [4:0] pick_reg();
        return ($urandom % 8 == 0) ? 5'd0 : 5'(1 + $urandom % 5);   // small pool
    endfunction

    function automatic logic [63:0] rand_pc();
        return {$urandom, $urandom} & ~64'd3;
    endfunction

    function automatic logic [31:0] rand_alu(input logic [4:0] rd);
        logic [2:0] f3;
        logic [11:0] imm;
        f3 = 3'($urandom);
        imm = 12'($urandom);
        if ($urandom % 2) begin
            return {((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2) ? 7'h20 : 7'h00,
                    pick_reg(), pick_reg(), f3, rd, 7'b0110011};
        end
        if (f3 == 3'd1) imm = {6'h00, imm[5:0]};
        if (f3 == 3'd5) imm = {1'b0, imm[10], 4'h0, imm[5:0]};
        return {imm, pick_reg(), f3, rd, 7'b0010011};
    endfunction

    initial begin
        int eb;
        logic [2:0] f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [4:0] r1;
        logic [6:0] opc;
        void'($urandom(73893));
        for (int k = 0; k < 32; k++) mregs[k] = '0;
        rst_n = 1'b0;
        instr_valid_i = 1'b0;
        instr_i = '0;
        pc_i = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        eb = errors;
        repeat (4) begin
            @(negedge clk);
            check("wb_valid", 64'd0, 64'(wb_valid_o));
            check("wb_wen", 64'd0, 64'(wb_wen_o));
            check("taken", 64'd0, 64'(branch_taken_o));
            check("illegal", 64'd0, 64'(illegal_o));
        end
        @(posedge clk);
        #1;
        finish_test(eb);

        cur_test = "alu_random";
        eb = errors;
        for (int n = 0; n < N_ALU; n++) send(rand_alu(pick_reg()), rand_pc());
        finish_test(eb);

        cur_test = "upper_link";
        eb = errors;
        for (int n = 0; n < N_UPPER; n++) begin
            case ($urandom % 4)
                0: send({20'($urandom), pick_reg(), 7'b0110111}, rand_pc());
                1: send({20'($urandom), pick_reg(), 7'b0010111}, rand_pc());
                2: send({20'($urandom), pick_reg(), 7'b1101111}, rand_pc());
                default: send({12'($urandom), pick_reg(), 3'd0, pick_reg(), 7'b1100111},
                              rand_pc());
            endcase
        end
        finish_test(eb);

        cur_test = "branches";
        eb = errors;
        for (int n = 0; n < N_BRANCH; n++) begin
            r1 = pick_reg();
            send({7'($urandom), ($urandom % 2) ? r1 : pick_reg(), r1, f3s[n % 6],
                  5'($urandom), 7'b1100011}, rand_pc());
        end
        finish_test(eb);

        cur_test = "x0_illegal";
        eb = errors;
        for (int n = 0; n < N_X0ILL / 2; n++) begin
            if (n % 3 == 2) send({7'h00, 5'd0, 5'd0, 3'd0, pick_reg(), 7'b0110011}, rand_pc());
            else send(rand_alu(5'd0), rand_pc());
        end
        for (int n = 0; n < N_X0ILL / 2; n++) begin
            do opc = 7'($urandom);
            while (opc inside {7'b0110011, 7'b0010011, 7'b0110111, 7'b0010111,
                               7'b1101111, 7'b1100111, 7'b1100011});
            send({$urandom} & 32'hffff_ff80 | {25'b0, opc}, rand_pc());
        end
        finish_test(eb);

        cur_test = "bubbles";
        eb = errors;
        for (int n = 0; n < N_BUBBLE; n++) begin
            send(rand_alu(pick_reg()), rand_pc());
            idle($urandom % 2);
        end
        finish_test(eb);

        errors += u_rv_exec_slice.u_chk.fail_count;
        $display("%0d tests run, %0d errors", tests_done, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* build.f */
src/rv_pkg.sv
src/uop_if.sv
src/rv_regfile.sv
src/rv_decode.sv
src/id_ex_regs.sv
src/rv_execute.sv
src/rv_writeback.sv
src/rv_exec_slice.sv
bench/rv_exec_slice_chk.sv
bench/tb_rv_exec_slice.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_exec_slice
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
